// ==== rtl/muldiv_pkg.sv ====
package muldiv_pkg;

    ////////////////////////////////////////
    // M-extension operations
    ////////////////////////////////////////

    // encoded as the funct3 field, bit 2 set for the divide class
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000, // low word
        OP_MULH   = 3'b001, // signed x signed, high word
        OP_MULHSU = 3'b010, // signed x unsigned, high word
        OP_MULHU  = 3'b011, // unsigned x unsigned, high word
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } md_op_e;

    ////////////////////////////////////////
    // divider FSM
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        DIV_IDLE = 3'd0,
        DIV_LOAD = 3'd1, // operand magnitudes
        DIV_ITER = 3'd2, // DIV_STEPS bits per cycle
        DIV_FIX  = 3'd3, // restore remainder, last quotient bit
        DIV_SIGN = 3'd4, // sign correction, result out
        DIV_DONE = 3'd5  // shortcut result held
    } div_state_e;

endpackage

// ==== rtl/md_multiplier.sv ====
`timescale 1ns/1ps

module md_multiplier (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               start_i,
    input  muldiv_pkg::md_op_e op_i,
    input  logic [31:0]        rs1_i,
    input  logic [31:0]        rs2_i,
    output logic [31:0]        product_o,
    output logic               done_o
);

    logic               a_sext;
    logic               b_sext;
    logic signed [32:0] a_q;
    logic signed [32:0] b_q;
    logic               hi_q;
    logic               s1_valid_q;
    logic               s2_valid_q;
    logic signed [65:0] full_prod;
    logic [31:0]        product_q;

    // MUL low word does not care about operand signs
    assign a_sext = (op_i == muldiv_pkg::OP_MULH) || (op_i == muldiv_pkg::OP_MULHSU);
    assign b_sext = (op_i == muldiv_pkg::OP_MULH);

    ////////////////////////////////////////
    // stage one, extended operands
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            a_q  <= {a_sext & rs1_i[31], rs1_i};
            b_q  <= {b_sext & rs2_i[31], rs2_i};
            hi_q <= (op_i != muldiv_pkg::OP_MUL);
        end
    end

    ////////////////////////////////////////
    // stage two, product half
    ////////////////////////////////////////

    assign full_prod = a_q * b_q;

    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            product_q <= hi_q ? full_prod[63:32] : full_prod[31:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= start_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    assign product_o = product_q;
    assign done_o    = s2_valid_q;

endmodule

// ==== rtl/md_divider.sv ====
`timescale 1ns/1ps

module md_divider #(
    parameter int DIV_STEPS = 8
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        start_i,
    input  logic        signed_i,
    input  logic [31:0] dividend_i,
    input  logic [31:0] divisor_i,
    output logic [31:0] quotient_o,
    output logic [31:0] remainder_o,
    output logic        done_o,
    output logic        busy_o
);

    localparam int ITERS = 32 / DIV_STEPS;
    localparam int CNT_W = $clog2(ITERS + 1);

    muldiv_pkg::div_state_e state_q;
    muldiv_pkg::div_state_e state_d;

    logic [32:0]      rem_q;     // partial remainder, bit 32 is the sign
    logic [31:0]      quo_q;     // dividend shifting out, quotient shifting in
    logic [31:0]      dvs_q;
    logic [32:0]      rem_step;
    logic [31:0]      quo_step;
    logic [CNT_W-1:0] cnt_q;
    logic             signed_q;
    logic             neg_quo_q;
    logic             neg_rem_q;
    logic             accept;
    logic             div_zero;
    logic             overflow;
    logic             too_big;
    logic             shortcut;

    assign busy_o = (state_q != muldiv_pkg::DIV_IDLE) && (state_q != muldiv_pkg::DIV_SIGN);
    assign done_o = (state_q == muldiv_pkg::DIV_SIGN);
    assign accept = start_i && !busy_o; // also taken in the done cycle

    assign div_zero = (divisor_i == 32'd0);
    assign overflow = signed_i && (dividend_i == 32'h8000_0000) && (divisor_i == 32'hffff_ffff);
    assign too_big  = !signed_i && (divisor_i > dividend_i);
    assign shortcut = div_zero || overflow || too_big;

    always_comb begin
        state_d = state_q;
        case (state_q)
            muldiv_pkg::DIV_LOAD: state_d = muldiv_pkg::DIV_ITER;
            muldiv_pkg::DIV_ITER: begin
                if (cnt_q == CNT_W'(1)) begin
                    state_d = muldiv_pkg::DIV_FIX;
                end
            end
            muldiv_pkg::DIV_FIX:  state_d = muldiv_pkg::DIV_SIGN;
            muldiv_pkg::DIV_DONE: state_d = muldiv_pkg::DIV_SIGN; // flags cleared, pass through
            default:              state_d = muldiv_pkg::DIV_IDLE;
        endcase
        if (accept) begin
            state_d = shortcut ? muldiv_pkg::DIV_DONE : muldiv_pkg::DIV_LOAD;
        end
    end

    ////////////////////////////////////////
    // non-restoring steps, quotient bit lags one step
    ////////////////////////////////////////

    always_comb begin
        logic        sign_bit;
        logic [32:0] shifted;
        rem_step = rem_q;
        quo_step = quo_q;
        for (int i = 0; i < DIV_STEPS; i++) begin
            sign_bit = rem_step[32];
            shifted  = {rem_step[31:0], quo_step[31]};
            if (sign_bit) begin
                rem_step = shifted + {1'b0, dvs_q};
            end else begin
                rem_step = shifted - {1'b0, dvs_q};
            end
            quo_step = {quo_step[30:0], ~sign_bit}; // first bit shifts out in fix
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q   <= muldiv_pkg::DIV_IDLE;
            cnt_q     <= '0;
            signed_q  <= 1'b0;
            neg_quo_q <= 1'b0;
            neg_rem_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                signed_q  <= signed_i;
                neg_quo_q <= 1'b0;
                neg_rem_q <= 1'b0;
            end else if (state_q == muldiv_pkg::DIV_LOAD) begin
                neg_quo_q <= signed_q && (quo_q[31] ^ dvs_q[31]);
                neg_rem_q <= signed_q && quo_q[31]; // follows the dividend
                cnt_q     <= CNT_W'(ITERS);
            end else if (state_q == muldiv_pkg::DIV_ITER) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            if (div_zero) begin
                quo_q <= 32'hffff_ffff;
                rem_q <= {1'b0, dividend_i};
            end else if (overflow) begin
                quo_q <= dividend_i;
                rem_q <= '0;
            end else if (too_big) begin
                quo_q <= 32'd0;
                rem_q <= {1'b0, dividend_i};
            end else begin
                quo_q <= dividend_i;
                dvs_q <= divisor_i;
                rem_q <= '0;
            end
        end else begin
            case (state_q)
                muldiv_pkg::DIV_LOAD: begin
                    if (signed_q && quo_q[31]) begin
                        quo_q <= -quo_q;
                    end
                    if (signed_q && dvs_q[31]) begin
                        dvs_q <= -dvs_q;
                    end
                end
                muldiv_pkg::DIV_ITER: begin
                    rem_q <= rem_step;
                    quo_q <= quo_step;
                end
                muldiv_pkg::DIV_FIX: begin
                    quo_q <= {quo_q[30:0], ~rem_q[32]};
                    if (rem_q[32]) begin
                        rem_q <= rem_q + {1'b0, dvs_q};
                    end
                end
                default: ;
            endcase
        end
    end

    assign quotient_o  = neg_quo_q ? -quo_q : quo_q;
    assign remainder_o = neg_rem_q ? -rem_q[31:0] : rem_q[31:0];

endmodule

// ==== rtl/muldiv_unit.sv ====
`timescale 1ns/1ps

module muldiv_unit #(
    parameter int DIV_STEPS = 8
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               req_i,
    input  muldiv_pkg::md_op_e op_i,
    input  logic [31:0]        rs1_i,
    input  logic [31:0]        rs2_i,
    output logic [31:0]        result_o,
    output logic               valid_o,
    output logic               busy_o
);

    logic        is_div;
    logic        take;
    logic        mul_start;
    logic        div_start;
    logic        div_signed;
    logic        rem_sel_q;
    logic [31:0] product;
    logic [31:0] quotient;
    logic [31:0] remainder;
    logic        mul_done;
    logic        div_done;
    logic        div_busy;

    ////////////////////////////////////////
    // request steering
    ////////////////////////////////////////

    assign is_div     = op_i[2]; // funct3 divide class
    assign take       = req_i && !div_busy;
    assign mul_start  = take && !is_div;
    assign div_start  = take && is_div;
    assign div_signed = (op_i == muldiv_pkg::OP_DIV) || (op_i == muldiv_pkg::OP_REM);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rem_sel_q <= 1'b0;
        end else if (div_start) begin
            rem_sel_q <= (op_i == muldiv_pkg::OP_REM) || (op_i == muldiv_pkg::OP_REMU);
        end
    end

    md_multiplier i_md_multiplier (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start_i   (mul_start),
        .op_i      (op_i),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .product_o (product),
        .done_o    (mul_done)
    );

    md_divider #(
        .DIV_STEPS (DIV_STEPS)
    ) i_md_divider (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (div_start),
        .signed_i    (div_signed),
        .dividend_i  (rs1_i),
        .divisor_i   (rs2_i),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .done_o      (div_done),
        .busy_o      (div_busy)
    );

    // busy blocks issue, so the two streams never collide
    assign result_o = div_done ? (rem_sel_q ? remainder : quotient) : product;
    assign valid_o  = mul_done || div_done;
    assign busy_o   = div_busy;

endmodule

// ==== test/md_divider_checker.sv ====
`timescale 1ns/1ps

module md_divider_checker (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   start_i,
    input logic                   busy_i,
    input logic                   done_i,
    input muldiv_pkg::div_state_e state_q_i,
    input muldiv_pkg::div_state_e state_d_i
);

    done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_i)
        done_i |=> !done_i)
        else $error("divider done_o high for more than one cycle");

    // a start in the done cycle may reload
    done_to_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        (done_i && !start_i) |-> (state_d_i == muldiv_pkg::DIV_IDLE))
        else $error("divider done_o without a return to idle");

    // every load or shortcut entry follows a start while not busy
    no_start_when_busy: assert property (@(posedge clk_i) disable iff (!rst_i)
        ((state_q_i == muldiv_pkg::DIV_LOAD) || (state_q_i == muldiv_pkg::DIV_DONE)) |->
            $past(start_i && !busy_i))
        else $error("divider accepted a start while busy");

    idle_after_reset: assert property (@(posedge clk_i)
        !rst_i |=> !busy_i)
        else $error("divider busy_o high after reset");

endmodule

bind md_divider md_divider_checker i_md_divider_checker (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .start_i   (start_i),
    .busy_i    (busy_o),
    .done_i    (done_o),
    .state_q_i (state_q),
    .state_d_i (state_d)
);

// ==== test/muldiv_unit_tb.sv ====
`timescale 1ns/1ps

module muldiv_unit_tb #(
    parameter int DIV_STEPS = 8
);

    localparam int          MUL_LAT   = 2;
    localparam int          SHORT_LAT = 2;
    localparam int          DIV_LAT   = 32 / DIV_STEPS + 3;
    localparam int          N_MUL     = 24;
    localparam int          N_DIV     = 32;
    localparam int          N_SPECIAL = 10;
    localparam int          N_BUSY    = 4; // two divides, each with a reject window
    localparam int          N_OPS     = N_MUL + N_DIV + N_SPECIAL + N_BUSY;
    localparam int          WATCHDOG  = N_OPS * (32 / DIV_STEPS + 5) + 100;
    localparam logic [31:0] SEED      = 32'hdcf9_1f18;

    logic               clk_i = 1'b0;
    logic               rst_i;
    logic               req_i;
    muldiv_pkg::md_op_e op_i;
    logic [31:0]        rs1_i;
    logic [31:0]        rs2_i;
    logic [31:0]        result_o;
    logic               valid_o;
    logic               busy_o;

    always #2 clk_i = ~clk_i;

    muldiv_unit #(
        .DIV_STEPS (DIV_STEPS)
    ) i_muldiv_unit (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req_i),
        .op_i     (op_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .result_o (result_o),
        .valid_o  (valid_o),
        .busy_o   (busy_o)
    );

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [31:0] ref_result(input muldiv_pkg::md_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
        logic [63:0] prod;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] r;
        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // signed x signed
        if (op == muldiv_pkg::OP_MULHSU) begin
            prod = {{32{a[31]}}, a} * {32'd0, b};
        end else if (op == muldiv_pkg::OP_MULHU || op == muldiv_pkg::OP_MUL) begin
            prod = {32'd0, a} * {32'd0, b};
        end
        if (b == 32'd0) begin
            q = 32'hffff_ffff;
            r = a;
        end else if (op == muldiv_pkg::OP_DIVU || op == muldiv_pkg::OP_REMU) begin
            q = a / b;
            r = a % b;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;
            r = 32'd0;
        end else begin
            ma = a[31] ? -a : a;
            mb = b[31] ? -b : b;
            q  = (a[31] ^ b[31]) ? -(ma / mb) : ma / mb; // toward zero
            r  = a[31] ? -(ma % mb) : ma % mb;          // sign of dividend
        end
        case (op)
            muldiv_pkg::OP_MUL:                      return prod[31:0];
            muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU: return q;
            muldiv_pkg::OP_REM, muldiv_pkg::OP_REMU: return r;
            default:                                 return prod[63:32];
        endcase
    endfunction

    function automatic logic is_divide_op(input muldiv_pkg::md_op_e op);
        return op inside {muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU,
                          muldiv_pkg::OP_REM, muldiv_pkg::OP_REMU};
    endfunction

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("ERR t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp));
        end
    endtask

    task automatic drive_request(input muldiv_pkg::md_op_e op, input logic [31:0] a,
                                 input logic [31:0] b);
        req_i = 1'b1;
        op_i  = op;
        rs1_i = a;
        rs2_i = b;
    endtask

    // one request, then wait for its result and check latency
    task automatic run_op(input muldiv_pkg::md_op_e op, input logic [31:0] a,
                          input logic [31:0] b, input int lat);
        logic [31:0] expv;
        int          waited;
        expv = ref_result(op, a, b);
        drive_request(op, a, b);
        @(negedge clk_i);
        req_i  = 1'b0;
        waited = 1;
        while (!valid_o && waited <= lat + 8) begin
            check_eq(busy_o, is_divide_op(op), "busy_o");
            @(negedge clk_i);
            waited++;
        end
        if (!valid_o) begin
            abort_run($sformatf("no result for %s after %0d cycles", op.name(), waited));
        end
        check_eq(waited, lat, "latency");
        check_eq(result_o, expv, "result_o");
        check_eq(busy_o, 1'b0, "busy_o");
        @(negedge clk_i);
        check_eq(valid_o, 1'b0, "valid_o");
    endtask

    task automatic reject_during_divide(input muldiv_pkg::md_op_e op, input logic [31:0] a,
                                        input logic [31:0] b);
        logic [31:0] expv;
        expv = ref_result(op, a, b);
        drive_request(op, a, b);
        @(negedge clk_i);
        for (int k = 1; k < DIV_LAT; k++) begin
            check_eq(busy_o, 1'b1, "busy_o");
            check_eq(valid_o, 1'b0, "valid_o");
            drive_request(k[0] ? muldiv_pkg::OP_MULHU : muldiv_pkg::OP_DIVU, $urandom(), 32'd3);
            @(negedge clk_i);
        end
        req_i = 1'b0;
        check_eq(valid_o, 1'b1, "valid_o");
        check_eq(result_o, expv, "result_o");
        for (int k = 0; k < DIV_LAT + 4; k++) begin
            @(negedge clk_i);
            check_eq(valid_o, 1'b0, "valid_o"); // nothing from the rejects
            check_eq(busy_o, 1'b0, "busy_o");
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset_idle();
        for (int k = 0; k < 8; k++) begin
            check_eq(valid_o, 1'b0, "valid_o");
            check_eq(busy_o, 1'b0, "busy_o");
            @(negedge clk_i);
        end
    endtask

    task automatic test_mul_stream();
        logic [31:0]        mul_exp [N_MUL];
        muldiv_pkg::md_op_e op;
        logic [31:0]        a;
        logic [31:0]        b;
        for (int k = 0; k < N_MUL + MUL_LAT + 1; k++) begin
            if (k >= MUL_LAT && k - MUL_LAT < N_MUL) begin
                check_eq(valid_o, 1'b1, "valid_o");
                check_eq(result_o, mul_exp[k-MUL_LAT], "result_o");
            end else begin
                check_eq(valid_o, 1'b0, "valid_o");
            end
            check_eq(busy_o, 1'b0, "busy_o");
            if (k < N_MUL) begin
                op = muldiv_pkg::md_op_e'(3'(k % 4));
                a  = (k < 4) ? 32'h8000_0000 : $urandom(); // corner pass first
                b  = (k < 4) ? 32'hffff_ffff : $urandom();
                mul_exp[k] = ref_result(op, a, b);
                drive_request(op, a, b);
            end else begin
                req_i = 1'b0;
            end
            @(negedge clk_i);
        end
    endtask

    task automatic test_div_regular();
        muldiv_pkg::md_op_e op;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        mag_b;
        logic [31:0]        tmp;
        for (int k = 0; k < N_DIV; k++) begin
            op    = muldiv_pkg::md_op_e'(3'(4 + k % 4));
            mag_b = $urandom() >> $urandom_range(1, 31);
            tmp   = $urandom();
            if (mag_b == 32'd0) begin
                mag_b = 32'd1;
            end
            if (op == muldiv_pkg::OP_DIV || op == muldiv_pkg::OP_REM) begin
                a = {k[2], tmp[30:0]}; // k[3:2] walks the sign pairs
                b = k[3] ? -mag_b : mag_b;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                    b = 32'hffff_fffe;
                end
            end else begin
                a = tmp | 32'd1;
                b = k[3] ? (mag_b | 32'h8000_0000) : mag_b;
                if (b > a) begin
                    tmp = a;
                    a   = b;
                    b   = tmp; // keep off the shortcut path
                end
            end
            run_op(op, a, b, DIV_LAT);
        end
    endtask

    task automatic test_div_special();
        logic [31:0] a;
        a = $urandom() >> 1;
        run_op(muldiv_pkg::OP_DIV,  32'hc001_d00d, 32'd0, SHORT_LAT);
        run_op(muldiv_pkg::OP_REM,  32'hc001_d00d, 32'd0, SHORT_LAT);
        run_op(muldiv_pkg::OP_DIVU, 32'h1234_5678, 32'd0, SHORT_LAT);
        run_op(muldiv_pkg::OP_REMU, 32'h1234_5678, 32'd0, SHORT_LAT);
        run_op(muldiv_pkg::OP_DIVU, 32'd0,         32'd0, SHORT_LAT);
        run_op(muldiv_pkg::OP_DIV,  32'h8000_0000, 32'hffff_ffff, SHORT_LAT);
        run_op(muldiv_pkg::OP_REM,  32'h8000_0000, 32'hffff_ffff, SHORT_LAT);
        run_op(muldiv_pkg::OP_DIVU, 32'h0000_0005, 32'h0000_1000, SHORT_LAT);
        run_op(muldiv_pkg::OP_REMU, 32'h7fff_ffff, 32'h8000_0000, SHORT_LAT);
        run_op(muldiv_pkg::OP_REMU, a, a | 32'h8000_0000, SHORT_LAT);
    endtask

    task automatic test_busy_reject();
        reject_during_divide(muldiv_pkg::OP_DIV,  32'h9abc_1234, 32'h0000_0137);
        reject_during_divide(muldiv_pkg::OP_REMU, 32'hf000_0000, 32'h0000_1234);
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        rst_i = 1'b0;
        req_i = 1'b0;
        op_i  = muldiv_pkg::OP_MUL;
        rs1_i = 32'd0;
        rs2_i = 32'd0;
        repeat (4) @(negedge clk_i);
        rst_i = 1'b1;
        test_reset_idle();
        test_mul_stream();
        test_div_regular();
        test_div_special();
        test_busy_reject();
        $display("No errors");
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk_i);
        abort_run($sformatf("timeout after %0d clock cycles, tests did not finish", WATCHDOG));
    end

endmodule

// ==== compile.f ====
rtl/muldiv_pkg.sv
rtl/md_multiplier.sv
rtl/md_divider.sv
rtl/muldiv_unit.sv
test/md_divider_checker.sv
test/muldiv_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the M-extension unit
# override on the command line, e.g. make run DIV_STEPS=4

VERILATOR ?= verilator
TOP       ?= muldiv_unit_tb
DIV_STEPS ?= 8
BUILD_DIR ?= obj_dir_s$(DIV_STEPS)
LOG       ?= sim_s$(DIV_STEPS).log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: all compile run sweep clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GDIV_STEPS=$(DIV_STEPS) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^No errors$$" $(LOG)

sweep:
	$(MAKE) run DIV_STEPS=1
	$(MAKE) run DIV_STEPS=4
	$(MAKE) run DIV_STEPS=8

clean:
	rm -rf obj_dir_s* sim_s*.log
